/* spi_reg_master.f */
source/spi_reg_pkg.sv
source/spi_shift_if.sv
source/spi_clk_div.sv
source/spi_shifter.sv
source/spi_reg_bridge.sv
source/spi_reg_master.sv
testbench/spi_tb_clock.sv
testbench/spi_reg_slave_model.sv
testbench/spi_reg_master_tb.sv

/* Bender.yml */
package:
  name: spi_reg_master

sources:
  - source/spi_reg_pkg.sv
  - source/spi_shift_if.sv
  - source/spi_clk_div.sv
  - source/spi_shifter.sv
  - source/spi_reg_bridge.sv
  - source/spi_reg_master.sv
  - target: test
    files:
      - testbench/spi_tb_clock.sv
      - testbench/spi_reg_slave_model.sv
      - testbench/spi_reg_master_tb.sv

/* testbench/spi_reg_master_tb.sv */
`timescale 1ns/1ps

module spi_reg_master_tb;

	localparam int ADDR_W   = 7;
	localparam int DATA_W   = 16;
	localparam int DIV      = 2;
	localparam int WIDTH    = 1 + ADDR_W + DATA_W;
	localparam int DEPTH    = 1 << ADDR_W;
	localparam int N_RANDOM = 200;
	localparam int N_SHAPE  = 8;
	// Every host command of the run, the ignored one included
	localparam int N_CMDS   = 2 + N_RANDOM + N_SHAPE + 3;
	// One frame in system clocks with room for the divider phase
	localparam int FRAME_CYCLES    = (WIDTH + 4) * 2 * DIV;
	localparam int RSP_TIMEOUT     = 2 * FRAME_CYCLES;
	localparam longint WATCHDOG_NS = 2 * N_CMDS * FRAME_CYCLES * 20;

	logic                 CLK50MHZ;
	logic                 RST;
	logic                 cmd_valid;
	spi_reg_pkg::spi_op_e cmd_op;
	logic [ADDR_W-1:0]    cmd_addr;
	logic [DATA_W-1:0]    cmd_wdata;
	logic                 busy;
	logic                 rsp_valid;
	logic [DATA_W-1:0]    rsp_rdata;
	logic                 spi_sck;
	logic                 spi_cs;
	logic                 spi_mosi;
	logic                 spi_miso;

	integer            seed;
	int                errors;
	int                tests_run;
	int                tests_bad;
	int                rsp_count;
	int                accepted;
	logic [DATA_W-1:0] ref_mem [DEPTH];

	spi_tb_clock #(.PERIOD_NS(20)) clock_inst (.CLK50MHZ(CLK50MHZ));

	spi_reg_master #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.DIV   (DIV)
	) spi_reg_master_inst (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.cmd_valid(cmd_valid),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_wdata(cmd_wdata),
		.busy     (busy),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	spi_reg_slave_model #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) slave_inst (
		.spi_sck (spi_sck),
		.spi_cs  (spi_cs),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso)
	);

	// Response pulses, sampled mid cycle
	always @(negedge CLK50MHZ) begin
		if (rsp_valid === 1'b1)
			rsp_count++;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR %0t: %s, got 'h%0h, expected 'h%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("ERROR %0t: %s", $time, what);
			errors++;
		end
	endtask

	function automatic int count_mem_mismatches();
		int n;
		n = 0;
		for (int i = 0; i < DEPTH; i++)
			if (slave_inst.mem[i] !== ref_mem[i])
				n++;
		return n;
	endfunction

	// One-cycle command pulse
	task automatic issue_cmd(
		input spi_reg_pkg::spi_op_e op,
		input logic [ADDR_W-1:0]    addr,
		input logic [DATA_W-1:0]    wdata
	);
		@(posedge CLK50MHZ);
		#2;
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_addr  = addr;
		cmd_wdata = wdata;
		@(posedge CLK50MHZ);
		#2;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_response(output logic [DATA_W-1:0] rdata, output bit got);
		int waited;
		got    = 1'b0;
		rdata  = '0;
		waited = 0;
		while (!got && waited < RSP_TIMEOUT) begin
			@(negedge CLK50MHZ);
			if (rsp_valid === 1'b1) begin
				got   = 1'b1;
				rdata = rsp_rdata;
			end
			waited++;
		end
		assert (got) else begin
			$display("rsp_valid never arrived within %0d cycles of a command", RSP_TIMEOUT);
			errors++;
		end
	endtask

	task automatic send_cmd(
		input  spi_reg_pkg::spi_op_e op,
		input  logic [ADDR_W-1:0]    addr,
		input  logic [DATA_W-1:0]    wdata,
		output logic [DATA_W-1:0]    rdata
	);
		bit got;
		issue_cmd(op, addr, wdata);
		accepted++;
		wait_response(rdata, got);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	////////////////////
	// Watchdog
	////////////////////

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin : main
		logic [DATA_W-1:0]    rdata;
		logic [DATA_W-1:0]    wdata;
		logic [ADDR_W-1:0]    addr;
		logic [ADDR_W-1:0]    other;
		spi_reg_pkg::spi_op_e op;
		bit                   got;
		int                   err0;
		int                   frames0;

		seed      = 32'hadef_7cc6;
		errors    = 0;
		tests_run = 0;
		tests_bad = 0;
		rsp_count = 0;
		accepted  = 0;
		RST       = 1'b1;
		cmd_valid = 1'b0;
		cmd_op    = spi_reg_pkg::OP_WRITE;
		cmd_addr  = '0;
		cmd_wdata = '0;

		// Device and reference start from the same random contents
		for (int i = 0; i < DEPTH; i++) begin
			ref_mem[i]        = $random(seed);
			slave_inst.mem[i] = ref_mem[i];
		end

		repeat (2) @(posedge CLK50MHZ);
		#2;
		RST = 1'b0;

		// 1. Idle after reset
		err0 = errors;
		repeat (20) begin
			@(negedge CLK50MHZ);
			check_true(spi_cs === 1'b1 && spi_sck === 1'b0 && spi_mosi === 1'b0,
				"SPI pins not idle after reset");
			check_true(busy === 1'b0 && rsp_valid === 1'b0, "status not idle after reset");
		end
		finish_test("reset state", err0);

		// 2. Write then read back
		err0  = errors;
		addr  = $random(seed);
		wdata = $random(seed);
		send_cmd(spi_reg_pkg::OP_WRITE, addr, wdata, rdata);
		ref_mem[addr] = wdata;
		check_value("device word after write", slave_inst.mem[addr], wdata);
		send_cmd(spi_reg_pkg::OP_READ, addr, '0, rdata);
		check_value("read back data", rdata, wdata);
		finish_test("write then read back", err0);

		// 3. Random reads and writes
		err0 = errors;
		for (int n = 0; n < N_RANDOM; n++) begin
			op    = ($random(seed) & 1) ? spi_reg_pkg::OP_READ : spi_reg_pkg::OP_WRITE;
			addr  = $random(seed);
			wdata = $random(seed);
			send_cmd(op, addr, wdata, rdata);
			if (op == spi_reg_pkg::OP_READ) begin
				check_value("random read data", rdata, ref_mem[addr]);
			end else begin
				ref_mem[addr] = wdata;
				check_value("device words differing after write", count_mem_mismatches(), 0);
			end
		end
		finish_test("random mix", err0);

		// 4. Frame shape as seen by the device
		err0 = errors;
		for (int n = 0; n < N_SHAPE; n++) begin
			op      = ($random(seed) & 1) ? spi_reg_pkg::OP_READ : spi_reg_pkg::OP_WRITE;
			addr    = $random(seed);
			wdata   = $random(seed);
			frames0 = slave_inst.frame_count;
			send_cmd(op, addr, wdata, rdata);
			if (op == spi_reg_pkg::OP_WRITE)
				ref_mem[addr] = wdata;
			check_value("frames per command", slave_inst.frame_count - frames0, 1);
			check_value("SCK rising edges in frame", slave_inst.last_edges, WIDTH);
			check_value("opcode at device", slave_inst.last_op, op);
			check_value("address at device", slave_inst.last_addr, addr);
		end
		finish_test("frame shape", err0);

		// 5. Command while busy is dropped
		err0    = errors;
		addr    = $random(seed);
		other   = addr + 1'b1;
		wdata   = ~ref_mem[addr];
		frames0 = slave_inst.frame_count;
		issue_cmd(spi_reg_pkg::OP_WRITE, addr, wdata);
		accepted++;
		repeat (3) @(posedge CLK50MHZ);
		#2;
		check_true(busy === 1'b1, "busy low while a frame is in flight");
		issue_cmd(spi_reg_pkg::OP_WRITE, other, ~ref_mem[other]);
		wait_response(rdata, got);
		ref_mem[addr] = wdata;
		repeat (RSP_TIMEOUT) @(posedge CLK50MHZ);
		check_value("responses after ignored command", rsp_count, accepted);
		check_value("frames after ignored command", slave_inst.frame_count - frames0, 1);
		check_value("device words differing", count_mem_mismatches(), 0);
		send_cmd(spi_reg_pkg::OP_READ, other, '0, rdata);
		check_value("untouched word", rdata, ref_mem[other]);
		@(posedge CLK50MHZ);
		check_value("responses per accepted command", rsp_count, accepted);
		finish_test("ignored command", err0);

		$display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* testbench/spi_reg_slave_model.sv */
`timescale 1ns/1ps

module spi_reg_slave_model #(
	parameter int ADDR_W = 7,
	parameter int DATA_W = 16
) (
	input  logic spi_sck,
	input  logic spi_cs,
	input  logic spi_mosi,
	output logic spi_miso
);

	localparam int WIDTH = 1 + ADDR_W + DATA_W;
	localparam int DEPTH = 1 << ADDR_W;

	// Register file, filled from outside before the first frame
	logic [DATA_W-1:0] mem [DEPTH];

	logic [WIDTH-1:0]  rx;
	logic [ADDR_W-1:0] addr_q;
	logic              op_q;
	logic              in_frame;
	int                edges;

	// Result of the last finished frame
	logic              last_op;
	logic [ADDR_W-1:0] last_addr;
	int                last_edges;
	int                frame_count;

	initial begin
		spi_miso    = 1'b0;
		rx          = '0;
		addr_q      = '0;
		op_q        = 1'b0;
		in_frame    = 1'b0;
		edges       = 0;
		last_op     = 1'b0;
		last_addr   = '0;
		last_edges  = 0;
		frame_count = 0;
	end

	// Start of frame
	always @(negedge spi_cs) begin
		in_frame = 1'b1;
		edges    = 0;
		rx       = '0;
	end

	// Gated SCK can show a zero-width pulse when CS and the SCK level
	// switch in the same step, so only a settled high level counts
	always @(posedge spi_sck) begin
		#1;
		if (spi_sck === 1'b1 && spi_cs === 1'b0) begin
			rx    = {rx[WIDTH-2:0], spi_mosi};
			edges = edges + 1;
			if (edges == ADDR_W + 1) begin
				op_q   = rx[ADDR_W];
				addr_q = rx[ADDR_W-1:0];
			end
			// Data phase, stored word MSB first
			if (edges > ADDR_W + 1 && edges <= WIDTH)
				spi_miso = mem[addr_q][WIDTH - edges];
			else
				spi_miso = 1'b0;
		end
	end

	// End of frame, a complete write updates the register
	always @(posedge spi_cs) begin
		if (in_frame) begin
			last_op    = op_q;
			last_addr  = addr_q;
			last_edges = edges;
			if (edges == WIDTH && op_q == spi_reg_pkg::OP_WRITE)
				mem[addr_q] = rx[DATA_W-1:0];
			frame_count = frame_count + 1;
			in_frame    = 1'b0;
			spi_miso    = 1'b0;
		end
	end

endmodule

/* testbench/spi_tb_clock.sv */
`timescale 1ns/1ps

module spi_tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic CLK50MHZ
);

	initial CLK50MHZ = 1'b0;

	// Free running, toggles every half period
	always #(PERIOD_NS / 2) CLK50MHZ = ~CLK50MHZ;

endmodule

/* source/spi_reg_master.sv */
`timescale 1ns/1ps

module spi_reg_master #(
	parameter int ADDR_W = 7,
	parameter int DATA_W = 16,
	parameter int DIV    = 2
) (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	// Host command port
	input  logic                 cmd_valid,
	input  spi_reg_pkg::spi_op_e cmd_op,
	input  logic [ADDR_W-1:0]    cmd_addr,
	input  logic [DATA_W-1:0]    cmd_wdata,
	output logic                 busy,
	output logic                 rsp_valid,
	output logic [DATA_W-1:0]    rsp_rdata,
	// SPI pins
	output logic                 spi_sck,
	output logic                 spi_cs,
	output logic                 spi_mosi,
	input  logic                 spi_miso
);

	// Opcode bit + address + data
	localparam int WIDTH = 1 + ADDR_W + DATA_W;

	logic sck_level;
	logic shift_tick;

	spi_shift_if #(.WIDTH(WIDTH)) shift_bus ();

	spi_clk_div #(
		.DIV(DIV)
	) spi_clk_div_inst (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.sck_level (sck_level),
		.shift_tick(shift_tick)
	);

	spi_shifter #(
		.WIDTH(WIDTH)
	) spi_shifter_inst (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.sck_level (sck_level),
		.shift_tick(shift_tick),
		.shift     (shift_bus.target),
		.spi_sck   (spi_sck),
		.spi_cs    (spi_cs),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso)
	);

	spi_reg_bridge #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) spi_reg_bridge_inst (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.cmd_valid(cmd_valid),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_wdata(cmd_wdata),
		.busy     (busy),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.shift    (shift_bus.initiator)
	);

endmodule

/* source/spi_reg_bridge.sv */
`timescale 1ns/1ps

module spi_reg_bridge #(
	parameter int ADDR_W = 7,
	parameter int DATA_W = 16
) (
	input  logic                CLK50MHZ,
	input  logic                RST,
	input  logic                cmd_valid,
	input  spi_reg_pkg::spi_op_e cmd_op,
	input  logic [ADDR_W-1:0]   cmd_addr,
	input  logic [DATA_W-1:0]   cmd_wdata,
	output logic                busy,
	output logic                rsp_valid,
	output logic [DATA_W-1:0]   rsp_rdata,
	spi_shift_if.initiator      shift
);

	localparam int WIDTH = 1 + ADDR_W + DATA_W;

	spi_reg_pkg::bridge_state_e state;
	logic [WIDTH-1:0]           frame_q;
	logic                       trig_q;
	logic                       accept;

	// A new command is taken whenever no frame is in flight
	assign accept = cmd_valid && !busy;

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= spi_reg_pkg::BR_IDLE;
		end else begin
			case (state)
				spi_reg_pkg::BR_IDLE:
					if (accept)
						state <= spi_reg_pkg::BR_START;
				spi_reg_pkg::BR_START:
					state <= spi_reg_pkg::BR_WAIT;
				spi_reg_pkg::BR_WAIT:
					if (shift.done)
						state <= spi_reg_pkg::BR_REPLY;
				spi_reg_pkg::BR_REPLY:
					// Back to back command may start right here
					if (accept)
						state <= spi_reg_pkg::BR_START;
					else
						state <= spi_reg_pkg::BR_IDLE;
				default:
					state <= spi_reg_pkg::BR_IDLE;
			endcase
		end
	end

	// Start pulse one cycle after BR_START
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			trig_q <= 1'b0;
		else
			trig_q <= (state == spi_reg_pkg::BR_START);
	end

	////////////////////
	// Frame pack and unpack
	////////////////////

	// Opcode, then address, then data; reads send zeros in the data field
	always_ff @(posedge CLK50MHZ) begin
		if (accept) begin
			frame_q[WIDTH-1]          <= cmd_op;
			frame_q[WIDTH-2 -: ADDR_W] <= cmd_addr;
			if (cmd_op == spi_reg_pkg::OP_READ)
				frame_q[DATA_W-1:0] <= '0;
			else
				frame_q[DATA_W-1:0] <= cmd_wdata;
		end
	end

	// Whatever the device sent in the data phase
	always_ff @(posedge CLK50MHZ) begin
		if (state == spi_reg_pkg::BR_WAIT && shift.done)
			rsp_rdata <= shift.frame_in[DATA_W-1:0];
	end

	assign busy = (state == spi_reg_pkg::BR_START) || (state == spi_reg_pkg::BR_WAIT);
	assign rsp_valid = (state == spi_reg_pkg::BR_REPLY);

	assign shift.frame_out = frame_q;
	assign shift.trig      = trig_q;

endmodule

/* source/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter #(
	parameter int WIDTH = 24
) (
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  logic        sck_level,
	input  logic        shift_tick,
	spi_shift_if.target shift,
	output logic        spi_sck,
	output logic        spi_cs,
	output logic        spi_mosi,
	input  logic        spi_miso
);

	// Counts WIDTH+1 ticks, so one extra bit of range
	localparam int CNT_W = $clog2(WIDTH + 1);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WIDTH);

	spi_reg_pkg::shift_state_e state;
	logic [WIDTH-1:0]          shift_reg;
	logic [CNT_W-1:0]          bit_cnt;

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= spi_reg_pkg::SHIFT_IDLE;
		end else begin
			case (state)
				spi_reg_pkg::SHIFT_IDLE:
					if (shift.trig)
						state <= spi_reg_pkg::SHIFT_SENDING;
				spi_reg_pkg::SHIFT_SENDING:
					if (shift_tick && bit_cnt == LAST_BIT)
						state <= spi_reg_pkg::SHIFT_DONE;
				spi_reg_pkg::SHIFT_DONE:
					state <= spi_reg_pkg::SHIFT_IDLE;
				default:
					state <= spi_reg_pkg::SHIFT_IDLE;
			endcase
		end
	end

	////////////////////
	// Datapath
	////////////////////

	// Keep loading while idle, the frame is stable once trig arrives
	always_ff @(posedge CLK50MHZ) begin
		case (state)
			spi_reg_pkg::SHIFT_IDLE:
				shift_reg <= shift.frame_out;
			spi_reg_pkg::SHIFT_SENDING:
				if (shift_tick)
					shift_reg <= {shift_reg[WIDTH-2:0], spi_miso};
			default:
				shift_reg <= shift_reg;
		endcase
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			bit_cnt <= '0;
		end else begin
			case (state)
				spi_reg_pkg::SHIFT_IDLE:
					bit_cnt <= '0;
				spi_reg_pkg::SHIFT_SENDING:
					if (shift_tick)
						bit_cnt <= bit_cnt + 1'b1;
				default:
					bit_cnt <= bit_cnt;
			endcase
		end
	end

	////////////////////
	// SPI pins
	////////////////////

	// MOSI changes together with the falling SCK edge
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_mosi <= 1'b0;
		end else begin
			case (state)
				spi_reg_pkg::SHIFT_SENDING:
					if (shift_tick)
						spi_mosi <= (bit_cnt == LAST_BIT) ? 1'b0 : shift_reg[WIDTH-1];
				default:
					spi_mosi <= 1'b0;
			endcase
		end
	end

	// CS low from the first tick until the count reaches WIDTH
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_cs <= 1'b1;
		end else begin
			case (state)
				spi_reg_pkg::SHIFT_SENDING:
					if (shift_tick)
						spi_cs <= (bit_cnt == LAST_BIT);
				default:
					spi_cs <= 1'b1;
			endcase
		end
	end

	// SCK only inside the chip select window, idles low
	assign spi_sck = spi_cs ? 1'b0 : sck_level;

	assign shift.frame_in = shift_reg;
	assign shift.done     = (state == spi_reg_pkg::SHIFT_DONE);

endmodule

/* source/spi_clk_div.sv */
`timescale 1ns/1ps

module spi_clk_div #(
	parameter int DIV = 2
) (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic sck_level,
	output logic shift_tick
);

	// One full SCK period is 2*DIV system clocks
	localparam int CNT_W = $clog2(2 * DIV);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(2 * DIV - 1);
	localparam logic [CNT_W-1:0] HALF = CNT_W'(DIV);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;

	always_comb begin
		if (cnt == LAST)
			cnt_next = '0;
		else
			cnt_next = cnt + 1'b1;
	end

	// Low half first, then high half
	// Tick sits in the last high cycle so the following edge
	// is the falling SCK edge
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt        <= '0;
			sck_level  <= 1'b0;
			shift_tick <= 1'b0;
		end else begin
			cnt        <= cnt_next;
			sck_level  <= (cnt_next >= HALF);
			shift_tick <= (cnt_next == LAST);
		end
	end

endmodule

/* source/spi_shift_if.sv */
`timescale 1ns/1ps

interface spi_shift_if #(
	parameter int WIDTH = 24
);
	// Frame to send, held from trig until done
	logic [WIDTH-1:0] frame_out;
	// Shift register contents, valid while done is high
	logic [WIDTH-1:0] frame_in;
	logic             trig;
	logic             done;

	modport initiator (
		output frame_out,
		output trig,
		input  frame_in,
		input  done
	);

	modport target (
		input  frame_out,
		input  trig,
		output frame_in,
		output done
	);

endinterface

/* source/spi_reg_pkg.sv */
package spi_reg_pkg;

	////////////////////
	// Command opcode
	////////////////////

	// First bit on the wire in every frame
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} spi_op_e;

	////////////////////
	// FSM states
	////////////////////

	// Frame shift engine
	typedef enum logic [1:0] {
		SHIFT_IDLE    = 2'd0,
		SHIFT_SENDING = 2'd1,
		SHIFT_DONE    = 2'd2
	} shift_state_e;

	// Command front end
	typedef enum logic [1:0] {
		BR_IDLE  = 2'd0,
		BR_START = 2'd1,
		BR_WAIT  = 2'd2,
		BR_REPLY = 2'd3
	} bridge_state_e;

endpackage
